/* common/axis_pkg.sv */
// stream beat layout, shared by every block on the 64-bit byte-lane datapath
`default_nettype none

package axis_pkg;

    // byte lanes per beat
    localparam int beat_bytes = 8;

    typedef logic [beat_bytes*8-1:0] data_t;

    // bit i set means lane i carries a valid byte
    typedef logic [beat_bytes-1:0] keep_t;

    // one transfer on the stream
    // user on a last beat marks an aborted frame
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

endpackage

`default_nettype wire

/* common/eth_pkg.sv */
// ethernet crc-32 and fcs constants, shared by the crc fold and the frame control
`default_nettype none

package eth_pkg;

    // running crc state, also the width of the fcs field
    typedef logic [31:0] crc_t;

    // ieee 802.3 generator, normal (msb first) form
    localparam crc_t crc_poly = 32'h04c11db7;

    // start value at the first byte of each frame
    localparam crc_t crc_init = 32'hffffffff;

    // bytes appended after the payload
    localparam int fcs_bytes = 4;

endpackage

`default_nettype wire

/* fcs_insert/fcs_crc64.sv */
// combinational crc-32 step over the kept bytes of one beat, instantiated by the fcs control
`default_nettype none

module fcs_crc64 (
    input  eth_pkg::crc_t   crc_in,
    input  axis_pkg::data_t data,
    input  axis_pkg::keep_t keep,
    output eth_pkg::crc_t   crc_out
);

    eth_pkg::crc_t poly_rev;
    eth_pkg::crc_t crc;
    logic          fb;

    // reflected crc shifts right, so the polynomial is bit reversed
    always_comb begin
        for (int i = 0; i < $bits(eth_pkg::crc_t); i++) begin
            poly_rev[i] = eth_pkg::crc_poly[$bits(eth_pkg::crc_t)-1-i];
        end
    end

    // lane 0 first, lsb of each byte first
    always_comb begin
        crc = crc_in;
        fb  = 1'b0;
        for (int lane = 0; lane < axis_pkg::beat_bytes; lane++) begin
            if (keep[lane]) begin
                for (int b = 0; b < 8; b++) begin
                    fb  = crc[0] ^ data[lane*8+b];
                    crc = {1'b0, crc[$bits(eth_pkg::crc_t)-1:1]};
                    if (fb) begin
                        crc = crc ^ poly_rev;
                    end
                end
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

/* fcs_insert/fcs_insert_ctrl.sv */
// frame control of the fcs inserter: lane masking, running crc and fcs placement into the stream
`default_nettype none

module fcs_insert_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output axis_pkg::axis_beat_t int_beat,
    output logic                 int_valid,
    input  logic                 in_ready,
    input  logic                 in_ready_early,
    output logic                 busy
);

    localparam int lane_w = axis_pkg::beat_bytes;
    localparam int data_w = axis_pkg::beat_bytes * 8;

    // two beats side by side, so the fcs may spill into the second one
    typedef logic [2*data_w-1:0] wide_data_t;
    typedef logic [2*lane_w-1:0] wide_keep_t;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_fcs
    } state_t;

    state_t               state_reg;
    state_t               state_next;
    eth_pkg::crc_t        crc_reg;
    eth_pkg::crc_t        crc_next;
    eth_pkg::crc_t        fcs;
    logic                 reset_crc;
    logic                 update_crc;
    logic                 s_ready_reg;
    logic                 s_ready_next;
    logic                 busy_reg;
    axis_pkg::axis_beat_t hold_reg;
    axis_pkg::axis_beat_t hold_next;
    logic                 hold_load;
    axis_pkg::data_t      masked;
    logic [3:0]           kept;
    wide_data_t           wide_data;
    wide_keep_t           wide_keep;

    assign s_ready = s_ready_reg;
    assign busy    = busy_reg;

    // zero unkept lanes and count the kept ones
    always_comb begin
        kept = '0;
        for (int i = 0; i < lane_w; i++) begin
            masked[i*8 +: 8] = s_beat.keep[i] ? s_beat.data[i*8 +: 8] : 8'd0;
            if (s_beat.keep[i]) begin
                kept = kept + 4'd1;
            end
        end
    end

    fcs_crc64 crc_step (
        .crc_in  (crc_reg),
        .data    (masked),
        .keep    (s_beat.keep),
        .crc_out (crc_next)
    );

    // fcs goes right after the last kept byte, low byte first
    assign fcs = ~crc_next;

    always_comb begin
        wide_data = wide_data_t'(masked) | (wide_data_t'(fcs) << {kept, 3'b000});
        wide_keep = wide_keep_t'(s_beat.keep)
                  | (wide_keep_t'({eth_pkg::fcs_bytes{1'b1}}) << kept);
    end

    // spill-over part, sent alone as the closing beat
    always_comb begin
        hold_next.data = wide_data[2*data_w-1:data_w];
        hold_next.keep = wide_keep[2*lane_w-1:lane_w];
        hold_next.last = 1'b1;
        hold_next.user = 1'b0;
    end

    always_comb begin
        state_next    = state_reg;
        s_ready_next  = 1'b0;
        reset_crc     = 1'b0;
        update_crc    = 1'b0;
        hold_load     = 1'b0;
        int_beat.data = masked;
        int_beat.keep = s_beat.keep;
        int_beat.last = 1'b0;
        int_beat.user = 1'b0;
        int_valid     = 1'b0;

        case (state_reg)
            st_idle, st_payload: begin
                s_ready_next = in_ready_early;
                int_valid    = s_valid && s_ready;
                if (s_valid && s_ready) begin
                    update_crc = 1'b1;
                    state_next = st_payload;
                    if (s_beat.last) begin
                        reset_crc     = 1'b1;
                        int_beat.last = 1'b1;
                        state_next    = st_idle;
                        if (s_beat.user) begin
                            // aborted frame, no fcs
                            int_beat.user = 1'b1;
                        end else begin
                            int_beat.data = wide_data[data_w-1:0];
                            int_beat.keep = wide_keep[lane_w-1:0];
                            if (wide_keep[2*lane_w-1:lane_w] != '0) begin
                                // fcs does not fit, one more beat needed
                                int_beat.last = 1'b0;
                                hold_load     = 1'b1;
                                s_ready_next  = 1'b0;
                                state_next    = st_fcs;
                            end
                        end
                    end
                end
            end
            st_fcs: begin
                int_beat  = hold_reg;
                int_valid = 1'b1;
                if (in_ready) begin
                    s_ready_next = in_ready_early;
                    state_next   = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg   <= st_idle;
            s_ready_reg <= 1'b0;
            busy_reg    <= 1'b0;
            crc_reg     <= eth_pkg::crc_init;
        end else begin
            state_reg   <= state_next;
            s_ready_reg <= s_ready_next;
            busy_reg    <= state_next != st_idle;
            if (reset_crc) begin
                crc_reg <= eth_pkg::crc_init;
            end else if (update_crc) begin
                crc_reg <= crc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_reg <= hold_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/axis_skid_buffer.sv */
// registered stream output stage with one overflow entry, absorbs back-pressure from the sink
`default_nettype none

module axis_skid_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic                 in_ready_early,
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    axis_pkg::axis_beat_t out_reg;
    axis_pkg::axis_beat_t ovf_reg;
    logic                 out_valid_reg;
    logic                 out_valid_next;
    logic                 ovf_valid_reg;
    logic                 ovf_valid_next;
    logic                 ready_reg;
    logic                 in_to_out;
    logic                 in_to_ovf;
    logic                 ovf_to_out;

    assign m_beat   = out_reg;
    assign m_valid  = out_valid_reg;
    assign in_ready = ready_reg;

    // overflow stays empty unless output is stalled with a beat arriving
    assign in_ready_early = m_ready || (!ovf_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        ovf_valid_next = ovf_valid_reg;
        in_to_out      = 1'b0;
        in_to_ovf      = 1'b0;
        ovf_to_out     = 1'b0;

        if (ready_reg) begin
            if (m_ready || !out_valid_reg) begin
                out_valid_next = in_valid;
                in_to_out      = 1'b1;
            end else begin
                ovf_valid_next = in_valid;
                in_to_ovf      = 1'b1;
            end
        end else if (m_ready) begin
            // input held off, drain the overflow entry
            out_valid_next = ovf_valid_reg;
            ovf_valid_next = 1'b0;
            ovf_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            ovf_valid_reg <= 1'b0;
            ready_reg     <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            ovf_valid_reg <= ovf_valid_next;
            ready_reg     <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_reg <= in_beat;
        end else if (ovf_to_out) begin
            out_reg <= ovf_reg;
        end
        if (in_to_ovf) begin
            ovf_reg <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* rtl/eth_fcs_insert.sv */
// top level of the ethernet fcs inserter, joins the frame control to the output buffer
`default_nettype none

module eth_fcs_insert (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready,
    output logic                 busy
);

    // control to buffer
    axis_pkg::axis_beat_t int_beat;
    logic                 int_valid;
    logic                 int_ready;
    logic                 int_ready_early;

    fcs_insert_ctrl ctrl (
        .clk            (clk),
        .rst            (rst),
        .s_beat         (s_beat),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .int_beat       (int_beat),
        .int_valid      (int_valid),
        .in_ready       (int_ready),
        .in_ready_early (int_ready_early),
        .busy           (busy)
    );

    axis_skid_buffer out_buf (
        .clk            (clk),
        .rst            (rst),
        .in_beat        (int_beat),
        .in_valid       (int_valid),
        .in_ready       (int_ready),
        .in_ready_early (int_ready_early),
        .m_beat         (m_beat),
        .m_valid        (m_valid),
        .m_ready        (m_ready)
    );

endmodule

`default_nettype wire

/* verif/eth_fcs_insert_sva.sv */
// stream port assertions for the fcs inserter, bound into the top level
`default_nettype none

module eth_fcs_insert_sva (
    input logic                 clk,
    input logic                 rst,
    input axis_pkg::axis_beat_t m_beat,
    input logic                 m_valid,
    input logic                 m_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // beat held while the sink stalls
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
    ) else $error("output beat changed while the sink stalled");

    // quiet during reset and the cycle after
    a_quiet_in_reset: assert property (
        @(posedge clk) rst |=> !m_valid
    ) else $error("m_valid high during or right after reset");

    // kept lanes start at lane 0 with no holes
    a_keep_shape: assert property (
        @(posedge clk) disable iff (rst)
        m_valid |-> ((m_beat.keep != 8'd0)
                     && ((m_beat.keep & (m_beat.keep + 8'd1)) == 8'd0))
    ) else $error("keep of an output beat is empty or not contiguous");

endmodule

bind eth_fcs_insert eth_fcs_insert_sva sva (
    .clk     (clk),
    .rst     (rst),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

`default_nettype wire

/* verif/tb_eth_fcs_insert.sv */
// testbench for the fcs inserter, random frames checked against a reference crc-32 model
`default_nettype none

module tb_eth_fcs_insert;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_frames  = 300;
    localparam int wait_limit  = 200;
    localparam int drain_limit = 2000;

    logic                 clk;
    logic                 rst;
    axis_pkg::axis_beat_t s_beat;
    logic                 s_valid;
    logic                 s_ready;
    axis_pkg::axis_beat_t m_beat;
    logic                 m_valid;
    logic                 m_ready;
    logic                 busy;

    // expected output bytes in stream order, plus one record per frame
    logic [7:0] exp_bytes[$];
    int         exp_total[$];
    int         exp_beats[$];
    int         exp_last_lanes[$];
    logic       exp_user[$];
    int         out_bytes;
    int         out_beats;
    int         frames_done;

    eth_fcs_insert DUT (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // reflected crc-32, one byte, lsb first
    function automatic eth_pkg::crc_t crc_byte(input eth_pkg::crc_t crc, input logic [7:0] value);
        eth_pkg::crc_t c;
        c = crc ^ {24'd0, value};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic send_beat(input axis_pkg::axis_beat_t beat);
        int waited;
        s_beat  = beat;
        s_valid = 1'b1;
        waited  = 0;
        // s_ready only moves on an edge, so its value here holds at the next one
        while (!s_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                fail_run("input side stalled, s_ready stayed low too long");
            end
        end
        @(posedge clk);
        #1;
        s_valid = 1'b0;
        // an accepted inner beat leaves the frame open
        if (!beat.last) begin
            check_value("busy inside frame", 1, 32'(busy));
        end
    endtask

    task automatic send_frame();
        axis_pkg::axis_beat_t beats[5];
        int                   len;
        int                   nbeats;
        int                   tail;
        logic                 abort;
        eth_pkg::crc_t        crc;
        logic [7:0]           value;
        len    = $urandom_range(40, 1);
        abort  = ($urandom_range(9) == 0);
        nbeats = (len + 7) / 8;
        tail   = len - 8 * (nbeats - 1);
        crc    = '1;
        for (int b = 0; b < nbeats; b++) begin
            // unkept lanes of the tail beat carry junk
            beats[b].data = {$urandom, $urandom};
            beats[b].keep = (b == nbeats - 1) ? (8'hff >> (8 - tail)) : 8'hff;
            beats[b].last = (b == nbeats - 1);
            beats[b].user = (b == nbeats - 1) && abort;
            for (int i = 0; i < 8; i++) begin
                if (beats[b].keep[i]) begin
                    value = beats[b].data[i*8 +: 8];
                    exp_bytes.push_back(value);
                    crc = crc_byte(crc, value);
                end
            end
        end
        if (abort) begin
            exp_total.push_back(len);
            exp_beats.push_back(nbeats);
            exp_last_lanes.push_back(tail);
        end else begin
            // fcs is the inverted crc, low byte first
            crc = ~crc;
            for (int i = 0; i < 4; i++) begin
                exp_bytes.push_back(crc[i*8 +: 8]);
            end
            exp_total.push_back(len + 4);
            exp_beats.push_back(tail > 4 ? nbeats + 1 : nbeats);
            exp_last_lanes.push_back(tail > 4 ? tail - 4 : tail + 4);
        end
        exp_user.push_back(abort);
        for (int b = 0; b < nbeats; b++) begin
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(3, 1)) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_beat(beats[b]);
        end
    endtask

    task automatic check_output_beat();
        int lanes;
        lanes = 0;
        if (exp_user.size() == 0) begin
            fail_run("output beat arrived with no frame outstanding");
        end
        for (int i = 0; i < 8; i++) begin
            if (m_beat.keep[i]) begin
                if (exp_bytes.size() == 0) begin
                    fail_run("output carried more bytes than were sent");
                end
                check_value("frame byte", 32'(exp_bytes.pop_front()), 32'(m_beat.data[i*8 +: 8]));
                lanes++;
            end else begin
                check_value("unkept lane", 0, 32'(m_beat.data[i*8 +: 8]));
            end
        end
        out_bytes += lanes;
        out_beats++;
        if (!m_beat.last) begin
            check_value("keep of inner beat", 32'hff, 32'(m_beat.keep));
            check_value("user of inner beat", 0, 32'(m_beat.user));
        end else begin
            check_value("frame length", exp_total.pop_front(), out_bytes);
            check_value("beats per frame", exp_beats.pop_front(), out_beats);
            check_value("lanes of final beat", exp_last_lanes.pop_front(), lanes);
            check_value("abort flag", 32'(exp_user.pop_front()), 32'(m_beat.user));
            out_bytes = 0;
            out_beats = 0;
            frames_done++;
        end
    endtask

    // values at the falling edge are the ones the next rising edge takes
    always @(negedge clk) begin
        if (!rst && m_valid && m_ready) begin
            check_output_beat();
        end
    end

    // sink ready about 70 % of cycles
    initial begin
        m_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            m_ready = ($urandom_range(99) < 70);
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h651f));
        rst         = 1'b1;
        s_valid     = 1'b0;
        s_beat      = '0;
        out_bytes   = 0;
        out_beats   = 0;
        frames_done = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("m_valid after reset", 0, 32'(m_valid));
        check_value("busy after reset", 0, 32'(busy));
        waited = 0;
        while (!s_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 10) begin
                fail_run("s_ready did not rise after reset");
            end
        end
        for (int f = 0; f < num_frames; f++) begin
            send_frame();
        end
        waited = 0;
        while (frames_done < num_frames) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > drain_limit) begin
                fail_run("not all frames came out of the inserter");
            end
        end
        repeat (20) @(posedge clk);
        #1;
        check_value("busy when idle", 0, 32'(busy));
        if (exp_bytes.size() != 0) begin
            fail_run("expected bytes left over after the last frame");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
common/axis_pkg.sv
common/eth_pkg.sv
fcs_insert/fcs_crc64.sv
fcs_insert/fcs_insert_ctrl.sv
rtl/axis_skid_buffer.sv
rtl/eth_fcs_insert.sv
verif/eth_fcs_insert_sva.sv
verif/tb_eth_fcs_insert.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_eth_fcs_insert
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
